//--- source/fp32_pkg.sv
`default_nettype none

package fp32_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // single-precision format
  ////////////////////////////////////////////////////////////////////////////

  localparam int EXP_W          = 8;
  localparam int MAN_W          = 23;   // stored mantissa, hidden bit not kept
  localparam int EXT_EXP_W      = 10;   // extra bits for over/underflow range
  localparam int FRACT28_W      = 28;   // carry, 1.23 mantissa, round and sticky
  localparam int SHIFT_W        = 5;
  localparam int EXP_MAX_FINITE = 254;

  // magnitudes only, the sign bit is put in front at the output
  localparam logic [EXP_W+MAN_W-1:0] INF_BITS  = {{EXP_W{1'b1}}, {MAN_W{1'b0}}};
  localparam logic [EXP_W+MAN_W-1:0] QNAN_BITS = {{EXP_W{1'b1}}, 1'b1, {(MAN_W-1){1'b0}}};
  localparam logic [EXP_W+MAN_W-1:0] SNAN_BITS = {{EXP_W{1'b1}}, 1'b0, {(MAN_W-1){1'b1}}};

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;
  } fp32_t;

  // exception word, msb first
  typedef struct packed {
    logic ovf;
    logic unf;
    logic snf;
    logic qnf;
    logic zf;
    logic ixf;
    logic ivf;
    logic inf;
    logic dzf;  // no divider here, stays 0
  } fpcsr_flags_t;

  typedef enum logic [1:0] {
    RM_NEAREST = 2'b00,
    RM_TO_ZERO = 2'b01,
    RM_TO_INFP = 2'b10,
    RM_TO_INFM = 2'b11
  } rmode_e;

endpackage

`default_nettype wire

//--- source/rnd_pkg.sv
`default_nettype none

package rnd_pkg;

  localparam int WORK_W = 35;  // align shifter width
  localparam int ALN_W  = 32;  // fraction kept after align, lsb is guard

  // special-case info carried along with every operand
  typedef struct packed {
    logic inv;       // invalid operation
    logic inf;       // an operand was infinity
    logic snan;      // signaling nan operand
    logic qnan;      // quiet nan operand
    logic nan_sign;  // sign to give the output nan
  } nan_flags_t;

  ////////////////////////////////////////////////////////////////////////////
  // source records
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                                rdy;
    logic                                sign;
    logic                                sub_zero;  // exact cancellation
    logic [fp32_pkg::SHIFT_W-1:0]        shl;
    logic [fp32_pkg::EXT_EXP_W-1:0]      exp_shl;   // exp if shifted left
    logic [fp32_pkg::EXT_EXP_W-1:0]      exp_sh0;   // exp if not shifted
    logic [fp32_pkg::FRACT28_W-1:0]      fract;
    nan_flags_t                          nan;
  } add_src_t;

  typedef struct packed {
    logic                                rdy;
    logic                                sign;
    logic [fp32_pkg::SHIFT_W-1:0]        shr;
    logic [fp32_pkg::EXT_EXP_W-1:0]      exp_shr;   // exp if shifted right
    logic                                shl;       // at most one left
    logic [fp32_pkg::EXT_EXP_W-1:0]      exp_shl;
    logic [fp32_pkg::EXT_EXP_W-1:0]      exp_sh0;
    logic [fp32_pkg::FRACT28_W-1:0]      fract;
    nan_flags_t                          nan;
  } mul_src_t;

  ////////////////////////////////////////////////////////////////////////////
  // stage records
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                           sign;
    logic [fp32_pkg::EXT_EXP_W-1:0] exp;
    logic [ALN_W-1:0]               fract;
    logic [1:0]                     rs;     // round, sticky
    nan_flags_t                     nan;
  } align_t;

  typedef struct packed {
    fp32_pkg::fp32_t        res;
    fp32_pkg::fpcsr_flags_t flags;
  } round_out_t;

endpackage

`default_nettype wire

//--- source/rnd_align.sv
`default_nettype none

module rnd_align (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      flush_i,   // drop the held operand
  input  wire                      adv_i,     // load stage 1
  input  wire fp32_pkg::rmode_e    rmode_i,
  input  wire rnd_pkg::add_src_t   add_i,
  input  wire rnd_pkg::mul_src_t   mul_i,
  output rnd_pkg::align_t          s1_o,
  output logic                     s1_rdy_o
);

  logic                               add_sign;  // add sign after zero rule
  logic                               sign;
  rnd_pkg::nan_flags_t                nan;
  logic [rnd_pkg::WORK_W-1:0]         fract35;
  logic                               carry;
  logic [fp32_pkg::SHIFT_W-1:0]       shr_src;   // shift asked by the source
  logic [fp32_pkg::SHIFT_W-1:0]       shr;       // incl. carry fixup
  logic [fp32_pkg::SHIFT_W-1:0]       shl;
  logic [fp32_pkg::EXT_EXP_W-1:0]     exp_shr;
  logic [fp32_pkg::EXT_EXP_W-1:0]     exp_shl;
  logic [fp32_pkg::EXT_EXP_W-1:0]     exp_sh0;
  logic [fp32_pkg::EXT_EXP_W-1:0]     exp;
  logic [rnd_pkg::WORK_W-1:0]         fract35sh;
  logic [rnd_pkg::WORK_W-1:0]         rmask;     // bits lost by right shift
  logic                               rsticky;
  logic                               lsticky;
  logic                               sticky;

  // exact zero of a subtraction is -0 only when rounding down
  assign add_sign = add_i.sub_zero ? (rmode_i == fp32_pkg::RM_TO_INFM) : add_i.sign;

  ////////////////////////////////////////////////////////////////////////////
  // source select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sign    = 1'b0;
    nan     = '0;
    fract35 = '0;
    shr_src = '0;
    shl     = '0;
    exp_shr = '0;
    exp_shl = '0;
    exp_sh0 = '0;
    if (add_i.rdy) begin
      sign    = add_sign;
      nan     = add_i.nan;
      fract35 = {{(rnd_pkg::WORK_W-fp32_pkg::FRACT28_W){1'b0}}, add_i.fract};
      shl     = add_i.shl;  // add never shifts right
      exp_shl = add_i.exp_shl;
      exp_sh0 = add_i.exp_sh0;
    end else if (mul_i.rdy) begin
      sign    = mul_i.sign;
      nan     = mul_i.nan;
      fract35 = {{(rnd_pkg::WORK_W-fp32_pkg::FRACT28_W){1'b0}}, mul_i.fract};
      shr_src = mul_i.shr;
      shl     = {{(fp32_pkg::SHIFT_W-1){1'b0}}, mul_i.shl};
      exp_shr = mul_i.exp_shr;
      exp_shl = mul_i.exp_shl;
      exp_sh0 = mul_i.exp_sh0;
    end
  end

  // overflow of the adder/multiplier fraction, zero when idle
  assign carry = fract35[fp32_pkg::FRACT28_W-1];
  assign shr   = (|shr_src) ? shr_src : {{(fp32_pkg::SHIFT_W-1){1'b0}}, carry};

  ////////////////////////////////////////////////////////////////////////////
  // shift and sticky
  ////////////////////////////////////////////////////////////////////////////

  assign fract35sh = (|shr) ? (fract35 >> shr) : (fract35 << shl);

  // right shift by n drops bits [n+1:0] below the round bit
  assign rmask   = ~({rnd_pkg::WORK_W{1'b1}} << ({1'b0, shr} + 6'd2));
  assign rsticky = |(fract35 & rmask);

  always_comb begin
    case (shl)
      5'd0:    lsticky = |fract35[1:0];
      5'd1:    lsticky = fract35[0];   // bit 1 became round
      default: lsticky = 1'b0;         // nothing below round left
    endcase
  end

  assign sticky = (|shr) ? rsticky : lsticky;

  always_comb begin
    if (|shr_src) begin
      exp = exp_shr;
    end else if (shl == '0) begin
      exp = exp_sh0 + {{(fp32_pkg::EXT_EXP_W-1){1'b0}}, carry};  // carry bumps exp
    end else begin
      exp = exp_shl;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_o.sign  <= sign;
      s1_o.exp   <= exp;
      s1_o.fract <= fract35sh[rnd_pkg::WORK_W-1:3];
      s1_o.rs    <= {fract35sh[2], sticky};
      s1_o.nan   <= nan;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      s1_rdy_o <= 1'b0;
    end else if (adv_i) begin
      s1_rdy_o <= add_i.rdy | mul_i.rdy;
    end
  end

  // the select above gives add priority and would hide a collision
  a_one_source: assert property (@(posedge clk) disable iff (rst)
    !(add_i.rdy && mul_i.rdy))
    else $error("add and mul ready in the same cycle");

endmodule

`default_nettype wire

//--- source/rnd_round.sv
`default_nettype none

module rnd_round (
  input  wire fp32_pkg::rmode_e  rmode_i,
  input  wire rnd_pkg::align_t   s1_i,
  output rnd_pkg::round_out_t    res_o
);

  logic                               guard;
  logic                               rbit;
  logic                               sbit;
  logic                               lost;      // inexact
  logic                               rnd_up;
  logic [rnd_pkg::ALN_W-1:0]          fract_rnd;
  logic                               renorm;    // carry out of the mantissa
  logic [fp32_pkg::EXT_EXP_W-1:0]     exp_rnd;
  logic [fp32_pkg::MAN_W:0]           fract24;   // with hidden bit
  logic                               den;       // hidden bit clear
  logic                               any_nan;

  assign guard = s1_i.fract[0];
  assign rbit  = s1_i.rs[1];
  assign sbit  = s1_i.rs[0];
  assign lost  = rbit | sbit;

  ////////////////////////////////////////////////////////////////////////////
  // rounding
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (rmode_i)
      fp32_pkg::RM_NEAREST: rnd_up = (rbit & sbit) | (guard & rbit & ~sbit);  // ties to even
      fp32_pkg::RM_TO_INFP: rnd_up = ~s1_i.sign & lost;
      fp32_pkg::RM_TO_INFM: rnd_up = s1_i.sign & lost;
      default:              rnd_up = 1'b0;  // to zero truncates
    endcase
  end

  assign fract_rnd = s1_i.fract + {{(rnd_pkg::ALN_W-1){1'b0}}, rnd_up};

  // 1.11..1 + 1 carries into bit 24
  assign renorm  = fract_rnd[fp32_pkg::MAN_W+1];
  assign exp_rnd = s1_i.exp + {{(fp32_pkg::EXT_EXP_W-1){1'b0}}, renorm};
  assign fract24 = renorm ? fract_rnd[fp32_pkg::MAN_W+1:1] : fract_rnd[fp32_pkg::MAN_W:0];
  assign den     = ~fract24[fp32_pkg::MAN_W];
  assign any_nan = s1_i.nan.snan | s1_i.nan.qnan;

  ////////////////////////////////////////////////////////////////////////////
  // result word and flags
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    res_o.flags     = '0;
    res_o.flags.snf = s1_i.nan.inv;
    res_o.flags.qnf = s1_i.nan.qnan;
    res_o.flags.ivf = s1_i.nan.inv | s1_i.nan.snan;
    res_o.res.sign  = s1_i.sign;
    if (any_nan) begin
      // nan in gives quiet nan out
      res_o.res.sign                  = s1_i.nan.nan_sign;
      {res_o.res.exp, res_o.res.man}  = fp32_pkg::QNAN_BITS;
    end else if (s1_i.nan.inv) begin
      {res_o.res.exp, res_o.res.man}  = fp32_pkg::SNAN_BITS;
    end else if ((exp_rnd > fp32_pkg::EXP_MAX_FINITE) || s1_i.nan.inf) begin
      {res_o.res.exp, res_o.res.man}  = fp32_pkg::INF_BITS;
      res_o.flags.ovf = ~s1_i.nan.inf;         // true infinity is exact
      res_o.flags.ixf = lost | ~s1_i.nan.inf;
      res_o.flags.inf = 1'b1;
    end else if (den) begin
      res_o.res.exp   = '0;
      res_o.res.man   = fract24[fp32_pkg::MAN_W-1:0];
      res_o.flags.ixf = lost;
      res_o.flags.unf = lost;                  // tiny and inexact
      res_o.flags.zf  = ~(|fract24);
    end else begin
      res_o.res.exp   = exp_rnd[fp32_pkg::EXP_W-1:0];
      res_o.res.man   = fract24[fp32_pkg::MAN_W-1:0];
      res_o.flags.ixf = lost;
    end
  end

  // align must leave nothing above bit 24 once rounded
  a_single_renorm: assert final ($isunknown(s1_i) || any_nan || s1_i.nan.inv ||
    s1_i.nan.inf || (fract_rnd[rnd_pkg::ALN_W-1:fp32_pkg::MAN_W+2] == '0))
    else $error("rounded fraction needs more than one renormalizing shift");

endmodule

`default_nettype wire

//--- source/rnd_wb_latch.sv
`default_nettype none

module rnd_wb_latch (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        flush_i,
  input  wire                        padv_wb_i,   // advance wb latches
  input  wire                        grant_wb_i,  // wb slot is ours
  input  wire                        do_rf_wb_i,  // another unit writes back
  input  wire rnd_pkg::round_out_t   res_i,
  output fp32_pkg::fp32_t            wb_res_o,
  output fp32_pkg::fpcsr_flags_t     wb_flags_o,
  output logic                       wb_rdy_o
);

  ////////////////////////////////////////////////////////////////////////////
  // write-back latches
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      wb_res_o   <= '0;
      wb_flags_o <= '0;
      wb_rdy_o   <= 1'b0;
    end else if (padv_wb_i) begin
      if (grant_wb_i) begin
        wb_res_o   <= res_i.res;
        wb_flags_o <= res_i.flags;
        wb_rdy_o   <= 1'b1;
      end else if (do_rf_wb_i) begin
        // other unit owns wb, result word kept
        wb_flags_o <= '0;
        wb_rdy_o   <= 1'b0;
      end
      // neither, hold
    end
  end

  // flush must win over a grant in the same cycle
  a_flush_no_rdy: assert property (@(posedge clk) disable iff (rst)
    flush_i |=> !wb_rdy_o)
    else $error("wb ready seen right after flush");

endmodule

`default_nettype wire

//--- source/fp32_rnd_top.sv
`default_nettype none

module fp32_rnd_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       flush_i,
  input  wire                       adv_i,
  input  wire                       padv_wb_i,
  input  wire                       grant_wb_i,
  input  wire                       do_rf_wb_i,
  input  wire fp32_pkg::rmode_e     rmode_i,
  input  wire rnd_pkg::add_src_t    add_i,
  input  wire rnd_pkg::mul_src_t    mul_i,
  output logic                      valid_o,     // one cycle ahead of wb
  output fp32_pkg::fp32_t           wb_res_o,
  output fp32_pkg::fpcsr_flags_t    wb_flags_o,
  output logic                      wb_rdy_o
);

  rnd_pkg::align_t      s1;
  logic                 s1_rdy;
  rnd_pkg::round_out_t  rnd_res;

  // stage 1, align and register
  rnd_align u_align (
    .clk      (clk),
    .rst      (rst),
    .flush_i  (flush_i),
    .adv_i    (adv_i),
    .rmode_i  (rmode_i),
    .add_i    (add_i),
    .mul_i    (mul_i),
    .s1_o     (s1),
    .s1_rdy_o (s1_rdy)
  );

  rnd_round u_round (
    .rmode_i (rmode_i),
    .s1_i    (s1),
    .res_o   (rnd_res)
  );

  rnd_wb_latch u_wb (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .padv_wb_i  (padv_wb_i),
    .grant_wb_i (grant_wb_i),
    .do_rf_wb_i (do_rf_wb_i),
    .res_i      (rnd_res),
    .wb_res_o   (wb_res_o),
    .wb_flags_o (wb_flags_o),
    .wb_rdy_o   (wb_rdy_o)
  );

  assign valid_o = s1_rdy;

endmodule

`default_nettype wire

//--- verification/tb_fp32_rnd.sv
`default_nettype none

module tb_fp32_rnd;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF        = 4;   // 8 ns period
  localparam int RST_CYCLES      = 16;
  localparam int CYCLES_PER_TEST = 40;

  // one line of the pattern file
  typedef struct packed {
    logic        is_mul;
    logic [1:0]  rm;
    logic        sign;
    logic        sub_zero;
    logic [4:0]  shr;
    logic [4:0]  shl;
    logic [9:0]  exp_shr;
    logic [9:0]  exp_shl;
    logic [9:0]  exp_sh0;
    logic [27:0] fract;
    logic [4:0]  nan;
    logic [31:0] res;     // expected wb word
    logic [8:0]  flags;   // expected flag word
    logic        rdy;     // expected wb_rdy
  } vec_t;

  logic clk, rst, flush, adv, padv_wb, grant_wb, do_rf_wb;
  fp32_pkg::rmode_e       rmode;
  rnd_pkg::add_src_t      add_src;
  rnd_pkg::mul_src_t      mul_src;
  logic                   valid;
  fp32_pkg::fp32_t        wb_res;
  fp32_pkg::fpcsr_flags_t wb_flags;
  logic                   wb_rdy;

  string names[$];
  string ctls[$];
  vec_t  vecs[$];
  bit    loaded;
  bit    file_ok;
  int    test_errs;  // mismatches in the running test
  int    n_pass;
  int    n_fail;

  fp32_rnd_top dut (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush),
    .adv_i      (adv),
    .padv_wb_i  (padv_wb),
    .grant_wb_i (grant_wb),
    .do_rf_wb_i (do_rf_wb),
    .rmode_i    (rmode),
    .add_i      (add_src),
    .mul_i      (mul_src),
    .valid_o    (valid),
    .wb_res_o   (wb_res),
    .wb_flags_o (wb_flags),
    .wb_rdy_o   (wb_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input string what,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("error %s %s: expected %h, actual %h", name, what, exp_v, act_v);
      test_errs++;
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line, name, ctl, src;
    int          rm, sgn, sz, shr, shl, rdy;
    logic [9:0]  e_shr, e_shl, e_sh0;
    logic [27:0] fract;
    logic [4:0]  nan;
    logic [31:0] res;
    logic [8:0]  flags;
    vec_t        v;
    fd = $fopen("verification/rnd_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file verification/rnd_patterns.txt");
      file_ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
      n = $sscanf(line, "%s %s %s %d %d %d %d %d %h %h %h %h %h %h %h %d",
                  name, ctl, src, rm, sgn, sz, shr, shl, e_shr, e_shl, e_sh0,
                  fract, nan, res, flags, rdy);
      if (n != 16) begin
        $display("pattern line could not be parsed: %s", line);
        file_ok = 1'b0;
        continue;
      end
      v = '{is_mul: (src == "m"), rm: rm[1:0], sign: sgn[0], sub_zero: sz[0],
            shr: shr[4:0], shl: shl[4:0], exp_shr: e_shr, exp_shl: e_shl,
            exp_sh0: e_sh0, fract: fract, nan: nan, res: res, flags: flags,
            rdy: rdy[0]};
      names.push_back(name);
      ctls.push_back(ctl);
      vecs.push_back(v);
    end
    $fclose(fd);
  endtask

  // one pattern: N load+wb, F load+flush, H hold wb, D wb owned by another unit
  // stage 1 is loaded in every case
  task automatic run_pattern(input int idx);
    vec_t              v;
    string             ctl;
    string             name;
    rnd_pkg::add_src_t a;
    rnd_pkg::mul_src_t m;
    v    = vecs[idx];
    ctl  = ctls[idx];
    name = names[idx];
    a    = '0;
    m    = '0;
    test_errs = 0;
    repeat ($urandom % 4) @(posedge clk);  // idle gap
    @(posedge clk);
    if (v.is_mul) begin
      m.rdy     = 1'b1;
      m.sign    = v.sign;
      m.shr     = v.shr;
      m.exp_shr = v.exp_shr;
      m.shl     = v.shl[0];
      m.exp_shl = v.exp_shl;
      m.exp_sh0 = v.exp_sh0;
      m.fract   = v.fract;
      m.nan     = rnd_pkg::nan_flags_t'(v.nan);
    end else begin
      a.rdy      = 1'b1;
      a.sign     = v.sign;
      a.sub_zero = v.sub_zero;
      a.shl      = v.shl;
      a.exp_shl  = v.exp_shl;
      a.exp_sh0  = v.exp_sh0;
      a.fract    = v.fract;
      a.nan      = rnd_pkg::nan_flags_t'(v.nan);
    end
    rmode   <= fp32_pkg::rmode_e'(v.rm);  // held through rounding
    add_src <= a;
    mul_src <= m;
    adv     <= 1'b1;
    @(posedge clk);
    adv         <= 1'b0;
    add_src.rdy <= 1'b0;
    mul_src.rdy <= 1'b0;
    if (ctl == "N" || ctl == "F") begin
      if (ctl == "N") begin
        padv_wb  <= 1'b1;
        grant_wb <= 1'b1;
      end else begin
        flush <= 1'b1;
      end
      @(negedge clk);
      compare_value(name, "valid", 32'd1, {31'd0, valid});
      @(posedge clk);
      padv_wb  <= 1'b0;
      grant_wb <= 1'b0;
      flush    <= 1'b0;
      @(negedge clk);
      if (ctl == "F") compare_value(name, "valid after flush", 32'd0, {31'd0, valid});
    end else begin
      // round output now differs from the latched word
      padv_wb  <= 1'b1;
      grant_wb <= 1'b0;
      do_rf_wb <= (ctl == "D");
      @(posedge clk);
      padv_wb  <= 1'b0;
      do_rf_wb <= 1'b0;
      @(negedge clk);  // outputs settled
    end
    compare_value(name, "result", v.res, wb_res);
    compare_value(name, "flags", {23'd0, v.flags}, {23'd0, wb_flags});
    compare_value(name, "wb_rdy", {31'd0, v.rdy}, {31'd0, wb_rdy});
    if (test_errs == 0) begin
      $display("test %0d %s passed", idx, name);
      n_pass++;
    end else begin
      $display("test %0d %s failed with %0d mismatches", idx, name, test_errs);
      n_fail++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(1));
    rst      = 1'b1;
    flush    = 1'b0;
    adv      = 1'b0;
    padv_wb  = 1'b0;
    grant_wb = 1'b0;
    do_rf_wb = 1'b0;
    rmode    = fp32_pkg::RM_NEAREST;
    add_src  = '0;
    mul_src  = '0;
    file_ok  = 1'b1;
    n_pass   = 0;
    n_fail   = 0;
    load_patterns();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    test_errs = 0;  // outputs must come out of reset cleared
    compare_value("reset", "valid", 32'd0, {31'd0, valid});
    compare_value("reset", "wb_rdy", 32'd0, {31'd0, wb_rdy});
    compare_value("reset", "result", 32'd0, wb_res);
    compare_value("reset", "flags", 32'd0, {23'd0, wb_flags});
    if (test_errs == 0) n_pass++;
    else n_fail++;
    $display("test reset %s", (test_errs == 0) ? "passed" : "failed");
    if (vecs.size() == 0) begin
      $display("no patterns were loaded, nothing was tested");
      file_ok = 1'b0;
    end
    for (int i = 0; i < vecs.size(); i++) begin
      run_pattern(i);
    end
    $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0 && file_ok) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #((vecs.size() * CYCLES_PER_TEST + RST_CYCLES + 8) * 2 * CLK_HALF);
    $display("timeout, the tests did not finish in the expected time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
source/fp32_pkg.sv
source/rnd_pkg.sv
source/rnd_align.sv
source/rnd_round.sv
source/rnd_wb_latch.sv
source/fp32_rnd_top.sv
verification/tb_fp32_rnd.sv

//--- verification/rnd_patterns.txt
# name ctl(N F D H) src(a m) rm sign sub_zero shr shl | hex: exp_shr exp_shl exp_sh0 fract nan
# expected, hex: result flags | then rdy; nan bits are inv inf snan qnan nan_sign
add_rne_exact      N a 0 0 0 0 0 000 000 07f 4000000 00 3f800000 000 1
add_rne_tie_even   N a 0 0 0 0 0 000 000 07f 4000004 00 3f800000 008 1
add_rne_tie_up     N a 0 0 0 0 0 000 000 07f 400000c 00 3f800002 008 1
add_rne_above_half N a 0 0 0 0 0 000 000 07f 4000006 00 3f800001 008 1
add_rne_carry      N a 0 0 0 0 0 000 000 07f 7fffffe 00 40000000 008 1
add_carry_tie      N a 0 0 0 0 0 000 000 07f 8000008 00 40000000 008 1
add_shl3           N a 0 0 0 0 3 000 070 000 0800000 00 38000000 000 1
rz_pos             N a 1 0 0 0 0 000 000 07f 4000001 00 3f800000 008 1
rp_pos             N a 2 0 0 0 0 000 000 07f 4000001 00 3f800001 008 1
rm_pos             N a 3 0 0 0 0 000 000 07f 4000001 00 3f800000 008 1
rz_neg             N a 1 1 0 0 0 000 000 07f 4000001 00 bf800000 008 1
rp_neg             N a 2 1 0 0 0 000 000 07f 4000001 00 bf800000 008 1
rm_neg             N a 3 1 0 0 0 000 000 07f 4000001 00 bf800001 008 1
mul_shr_sticky     N m 2 0 0 1 0 085 000 000 8000003 00 42800001 008 1
mul_denorm         N m 0 0 0 3 0 000 000 000 4000010 00 00100000 088 1
mul_shl1           N m 0 0 0 0 1 000 07e 000 2000001 00 3f000000 008 1
mul_zero           N m 0 0 0 0 0 000 000 000 0000000 00 00000000 010 1
add_ovf            N a 0 1 0 0 0 000 000 0fe 7fffffe 00 ff800000 10a 1
inf_in             N a 0 0 0 0 0 000 000 0ff 4000000 08 7f800000 002 1
qnan_in            N m 0 0 0 0 0 000 000 0ff 6000000 03 ffc00000 020 1
snan_in            N m 0 0 0 0 0 000 000 0ff 5000000 04 7fc00000 004 1
invalid            N m 0 0 0 0 0 000 000 0ff 4000000 10 7fbfffff 044 1
cancel_rne         N a 0 1 1 0 0 000 000 000 0000000 00 00000000 010 1
cancel_rm          N a 3 1 1 0 0 000 000 000 0000000 00 80000000 010 1
ctl_flush          F a 0 0 0 0 0 000 000 07f 4000000 00 00000000 000 0
ctl_load           N a 0 0 0 0 0 000 000 07f 6000001 00 3fc00000 008 1
ctl_hold           H a 0 0 0 0 0 000 000 000 0000000 00 3fc00000 008 1
ctl_no_grant       D a 0 0 0 0 0 000 000 000 0000000 00 3fc00000 000 0
